/* rtl/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data path and byte address width
`define XLEN 32

// Register index width, 32 architectural registers
`define REG_ADDR_W 5

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* rtl/core_pkg.sv */
`include "core_params.svh"

package core_pkg;

	typedef logic [`XLEN-1:0]       word_t;
	typedef logic [`XLEN-1:0]       addr_t;
	typedef logic [31:0]            inst_t;
	typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
	// One bit per data bit, every lane all set or all clear
	typedef logic [`XLEN-1:0]       wmask_t;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
		ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_COPY_OP2
	} alu_op_t;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
	} br_op_t;

	// Result source at retire
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_NONE} wb_sel_t;

	// Data port command codes
	typedef enum logic [2:0] {
		MEM_NONE  = 3'd0,
		MEM_READ  = 3'd1,
		MEM_WRITE = 3'd2
	} mem_cmd_t;

	typedef enum logic {SIZE_BYTE, SIZE_WORD} mem_size_t;

	typedef enum logic [1:0] {
		F_ISSUE, F_WAIT_INST, F_WAIT_RETIRE, F_HALT
	} fetch_state_t;

	typedef enum logic [1:0] {M_IDLE, M_ISSUE, M_WAIT_DATA} mem_state_t;

endpackage

/* rtl/stage_if.sv */
`timescale 1ns/10ps

// Fetch to decode
interface fetch_dec_if;
	logic             valid;
	core_pkg::addr_t  pc;
	core_pkg::inst_t  inst;

	modport src (output valid, pc, inst);
	modport dst (input valid, pc, inst);
endinterface

// Decode to execute, operands already selected
interface dec_exe_if;
	logic                 valid;
	core_pkg::addr_t      pc;
	core_pkg::word_t      op1;
	core_pkg::word_t      op2;
	core_pkg::word_t      rs2_data;
	core_pkg::word_t      imm;
	core_pkg::alu_op_t    alu_op;
	core_pkg::br_op_t     br_op;
	core_pkg::mem_cmd_t   mem_cmd;
	core_pkg::mem_size_t  mem_size;
	core_pkg::wb_sel_t    wb_sel;
	core_pkg::reg_idx_t   rd;
	logic                 is_ecall;

	modport src (output valid, pc, op1, op2, rs2_data, imm, alu_op, br_op,
		mem_cmd, mem_size, wb_sel, rd, is_ecall);
	modport dst (input valid, pc, op1, op2, rs2_data, imm, alu_op, br_op,
		mem_cmd, mem_size, wb_sel, rd, is_ecall);
endinterface

// Execute to memory
interface exe_mem_if;
	logic                 valid;
	core_pkg::addr_t      pc;
	core_pkg::word_t      alu_out;
	core_pkg::word_t      rs2_data;
	core_pkg::mem_cmd_t   mem_cmd;
	core_pkg::mem_size_t  mem_size;
	core_pkg::wb_sel_t    wb_sel;
	core_pkg::reg_idx_t   rd;
	core_pkg::addr_t      next_pc;
	logic                 is_ecall;

	modport src (output valid, pc, alu_out, rs2_data, mem_cmd, mem_size,
		wb_sel, rd, next_pc, is_ecall);
	modport dst (input valid, pc, alu_out, rs2_data, mem_cmd, mem_size,
		wb_sel, rd, next_pc, is_ecall);
endinterface

/* rtl/fetch_stage.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module fetch_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               inst_ready,
	input  core_pkg::inst_t    inst,
	input  logic               inst_valid,
	input  logic               retire,
	input  core_pkg::addr_t    next_pc,
	input  logic               halt,
	output logic               inst_start,
	output core_pkg::addr_t    inst_addr,
	output logic               halted,
	fetch_dec_if.src           fd
);

	core_pkg::fetch_state_t state;
	core_pkg::addr_t        pc;

	// Request leaves as soon as the port can take it
	assign inst_start = (state == core_pkg::F_ISSUE) && inst_ready;
	assign inst_addr  = pc;
	assign halted     = (state == core_pkg::F_HALT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= core_pkg::F_ISSUE;
			pc       <= `RESET_PC;
			fd.valid <= 1'b0;
		end else begin
			fd.valid <= 1'b0;
			case (state)
				core_pkg::F_ISSUE: begin
					if (inst_ready)
						state <= core_pkg::F_WAIT_INST;
				end
				core_pkg::F_WAIT_INST: begin
					if (inst_valid) begin
						fd.valid <= 1'b1;
						state    <= core_pkg::F_WAIT_RETIRE;
					end
				end
				core_pkg::F_WAIT_RETIRE: begin
					if (retire && halt) begin
						state <= core_pkg::F_HALT;
					end else if (retire) begin
						pc    <= next_pc;
						state <= core_pkg::F_ISSUE;
					end
				end
				// ECALL parks the core here for good
				default: state <= core_pkg::F_HALT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == core_pkg::F_WAIT_INST && inst_valid) begin
			fd.inst <= inst;
			fd.pc   <= pc;
		end
	end

	// Memory only answers the one request it accepted
	a_valid_expected: assert property (@(posedge clk) disable iff (!rst_n)
		inst_valid |-> state == core_pkg::F_WAIT_INST);

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module decode_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                rd_wen,
	input  core_pkg::reg_idx_t  rd,
	input  core_pkg::word_t     rd_data,
	fetch_dec_if.dst            fd,
	dec_exe_if.src              de
);

	core_pkg::word_t      regs [2**`REG_ADDR_W];
	logic [6:0]           opcode;
	logic [2:0]           funct3;
	core_pkg::reg_idx_t   rs1_idx;
	core_pkg::reg_idx_t   rs2_idx;
	core_pkg::word_t      rs1_data;
	core_pkg::word_t      rs2_data;
	core_pkg::word_t      imm_i;
	core_pkg::word_t      imm_s;
	core_pkg::word_t      imm_b;
	core_pkg::word_t      imm_j;
	core_pkg::word_t      imm_u;
	core_pkg::word_t      imm;
	core_pkg::alu_op_t    arith_op;
	core_pkg::alu_op_t    alu_op;
	core_pkg::br_op_t     br_op;
	core_pkg::mem_cmd_t   mem_cmd;
	core_pkg::mem_size_t  mem_size;
	core_pkg::wb_sel_t    wb_sel;
	logic                 op1_pc;
	logic                 op2_imm;
	logic                 is_ecall;

	assign opcode  = fd.inst[6:0];
	assign funct3  = fd.inst[14:12];
	assign rs1_idx = fd.inst[19:15];
	assign rs2_idx = fd.inst[24:20];

	//**************************************************************************
	// Register file, x0 hardwired to zero
	//**************************************************************************
	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

	always_ff @(posedge clk) begin
		if (rd_wen && rd != '0)
			regs[rd] <= rd_data;
	end

	// Immediate formats
	assign imm_i = {{20{fd.inst[31]}}, fd.inst[31:20]};
	assign imm_s = {{20{fd.inst[31]}}, fd.inst[31:25], fd.inst[11:7]};
	assign imm_b = {{19{fd.inst[31]}}, fd.inst[31], fd.inst[7], fd.inst[30:25],
		fd.inst[11:8], 1'b0};
	assign imm_j = {{11{fd.inst[31]}}, fd.inst[31], fd.inst[19:12], fd.inst[20],
		fd.inst[30:21], 1'b0};
	assign imm_u = {fd.inst[31:12], 12'h000};

	// Shared by OP and OP-IMM; bit 30 picks SUB only in the register form
	always_comb begin
		case (funct3)
			3'b000:  arith_op = (opcode[5] && fd.inst[30]) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
			3'b001:  arith_op = core_pkg::ALU_SLL;
			3'b010:  arith_op = core_pkg::ALU_SLT;
			3'b011:  arith_op = core_pkg::ALU_SLTU;
			3'b100:  arith_op = core_pkg::ALU_XOR;
			3'b101:  arith_op = fd.inst[30] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
			3'b110:  arith_op = core_pkg::ALU_OR;
			default: arith_op = core_pkg::ALU_AND;
		endcase
	end

	//**************************************************************************
	// Control decode
	//**************************************************************************
	always_comb begin
		alu_op   = core_pkg::ALU_ADD;
		br_op    = core_pkg::BR_NONE;
		mem_cmd  = core_pkg::MEM_NONE;
		mem_size = core_pkg::SIZE_WORD;
		wb_sel   = core_pkg::WB_NONE;
		imm      = imm_i;
		op1_pc   = 1'b0;
		op2_imm  = 1'b1;
		is_ecall = 1'b0;
		case (opcode)
			7'b0110111: begin
				alu_op = core_pkg::ALU_COPY_OP2;
				imm    = imm_u;
				wb_sel = core_pkg::WB_ALU;
			end
			7'b0010111: begin
				op1_pc = 1'b1;
				imm    = imm_u;
				wb_sel = core_pkg::WB_ALU;
			end
			// JAL target also comes out of the adder
			7'b1101111: begin
				op1_pc = 1'b1;
				imm    = imm_j;
				br_op  = core_pkg::BR_JUMP;
				wb_sel = core_pkg::WB_PC4;
			end
			7'b1100111: begin
				br_op  = core_pkg::BR_JUMP;
				wb_sel = core_pkg::WB_PC4;
			end
			7'b1100011: begin
				imm = imm_b;
				case (funct3)
					3'b000:  br_op = core_pkg::BR_EQ;
					3'b001:  br_op = core_pkg::BR_NE;
					3'b100:  br_op = core_pkg::BR_LT;
					3'b101:  br_op = core_pkg::BR_GE;
					3'b110:  br_op = core_pkg::BR_LTU;
					3'b111:  br_op = core_pkg::BR_GEU;
					default: is_ecall = 1'b1;
				endcase
			end
			// Word loads only
			7'b0000011: begin
				if (funct3 == 3'b010) begin
					mem_cmd = core_pkg::MEM_READ;
					wb_sel  = core_pkg::WB_MEM;
				end else begin
					is_ecall = 1'b1;
				end
			end
			7'b0100011: begin
				imm      = imm_s;
				mem_cmd  = core_pkg::MEM_WRITE;
				mem_size = (funct3 == 3'b000) ? core_pkg::SIZE_BYTE : core_pkg::SIZE_WORD;
				if (funct3 != 3'b000 && funct3 != 3'b010) begin
					mem_cmd  = core_pkg::MEM_NONE;
					is_ecall = 1'b1;
				end
			end
			7'b0010011, 7'b0110011: begin
				alu_op  = arith_op;
				op2_imm = !opcode[5];
				wb_sel  = core_pkg::WB_ALU;
			end
			// ECALL, and anything not understood, halts
			default: is_ecall = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			de.valid <= 1'b0;
		else
			de.valid <= fd.valid;
	end

	always_ff @(posedge clk) begin
		if (fd.valid) begin
			de.pc       <= fd.pc;
			de.op1      <= op1_pc ? fd.pc : rs1_data;
			de.op2      <= op2_imm ? imm : rs2_data;
			de.rs2_data <= rs2_data;
			de.imm      <= imm;
			de.alu_op   <= alu_op;
			de.br_op    <= br_op;
			de.mem_cmd  <= mem_cmd;
			de.mem_size <= mem_size;
			de.wb_sel   <= wb_sel;
			de.rd       <= fd.inst[11:7];
			de.is_ecall <= is_ecall;
		end
	end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
	input  logic       clk,
	input  logic       rst_n,
	dec_exe_if.dst     de,
	exe_mem_if.src     em
);

	core_pkg::word_t  alu_res;
	logic [4:0]       shamt;
	logic             taken;
	core_pkg::addr_t  next_pc;

	assign shamt = de.op2[4:0];

	always_comb begin
		case (de.alu_op)
			core_pkg::ALU_SUB:      alu_res = de.op1 - de.op2;
			core_pkg::ALU_AND:      alu_res = de.op1 & de.op2;
			core_pkg::ALU_OR:       alu_res = de.op1 | de.op2;
			core_pkg::ALU_XOR:      alu_res = de.op1 ^ de.op2;
			core_pkg::ALU_SLL:      alu_res = de.op1 << shamt;
			core_pkg::ALU_SRL:      alu_res = de.op1 >> shamt;
			core_pkg::ALU_SRA:      alu_res = $signed(de.op1) >>> shamt;
			core_pkg::ALU_SLT:      alu_res = {31'b0, $signed(de.op1) < $signed(de.op2)};
			core_pkg::ALU_SLTU:     alu_res = {31'b0, de.op1 < de.op2};
			core_pkg::ALU_COPY_OP2: alu_res = de.op2;
			default:                alu_res = de.op1 + de.op2;
		endcase
	end

	// Conditional branches compare rs1 with rs2
	always_comb begin
		case (de.br_op)
			core_pkg::BR_EQ:  taken = de.op1 == de.rs2_data;
			core_pkg::BR_NE:  taken = de.op1 != de.rs2_data;
			core_pkg::BR_LT:  taken = $signed(de.op1) < $signed(de.rs2_data);
			core_pkg::BR_GE:  taken = $signed(de.op1) >= $signed(de.rs2_data);
			core_pkg::BR_LTU: taken = de.op1 < de.rs2_data;
			core_pkg::BR_GEU: taken = de.op1 >= de.rs2_data;
			default:          taken = 1'b0;
		endcase
	end

	// Jumps take the adder sum, pc+imm for JAL and rs1+imm for JALR
	always_comb begin
		if (de.br_op == core_pkg::BR_JUMP)
			next_pc = {alu_res[31:1], 1'b0};
		else if (taken)
			next_pc = de.pc + de.imm;
		else
			next_pc = de.pc + 32'd4;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			em.valid <= 1'b0;
		else
			em.valid <= de.valid;
	end

	always_ff @(posedge clk) begin
		if (de.valid) begin
			em.pc       <= de.pc;
			em.alu_out  <= alu_res;
			em.rs2_data <= de.rs2_data;
			em.mem_cmd  <= de.mem_cmd;
			em.mem_size <= de.mem_size;
			em.wb_sel   <= de.wb_sel;
			em.rd       <= de.rd;
			em.next_pc  <= next_pc;
			em.is_ecall <= de.is_ecall;
		end
	end

endmodule

/* rtl/memory_stage.sv */
`timescale 1ns/10ps

module memory_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                d_cmd_ready,
	input  core_pkg::word_t     rdata,
	input  logic                rdata_valid,
	exe_mem_if.dst              em,
	output core_pkg::mem_cmd_t  d_cmd,
	output core_pkg::addr_t     d_addr,
	output core_pkg::word_t     wdata,
	output core_pkg::wmask_t    wmask,
	output logic                retire,
	output core_pkg::reg_idx_t  rd,
	output core_pkg::word_t     rd_data,
	output logic                rd_wen,
	output core_pkg::addr_t     next_pc,
	output logic                halt
);

	core_pkg::mem_state_t  state;
	core_pkg::mem_cmd_t    cmd_q;
	core_pkg::wb_sel_t     wb_sel_q;
	core_pkg::word_t       result_q;
	core_pkg::word_t       load_q;

	// Command is only shown in a cycle the port accepts it
	assign d_cmd   = (state == core_pkg::M_ISSUE && d_cmd_ready) ? cmd_q : core_pkg::MEM_NONE;
	assign rd_data = (wb_sel_q == core_pkg::WB_MEM) ? load_q : result_q;
	assign rd_wen  = retire && wb_sel_q != core_pkg::WB_NONE && rd != '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= core_pkg::M_IDLE;
			retire <= 1'b0;
		end else begin
			retire <= 1'b0;
			case (state)
				core_pkg::M_IDLE: begin
					if (em.valid && em.mem_cmd == core_pkg::MEM_NONE)
						retire <= 1'b1;
					else if (em.valid)
						state <= core_pkg::M_ISSUE;
				end
				core_pkg::M_ISSUE: begin
					// A write is done once accepted
					if (d_cmd_ready && cmd_q == core_pkg::MEM_WRITE) begin
						retire <= 1'b1;
						state  <= core_pkg::M_IDLE;
					end else if (d_cmd_ready) begin
						state <= core_pkg::M_WAIT_DATA;
					end
				end
				core_pkg::M_WAIT_DATA: begin
					if (rdata_valid) begin
						retire <= 1'b1;
						state  <= core_pkg::M_IDLE;
					end
				end
				default: state <= core_pkg::M_IDLE;
			endcase
		end
	end

	//**************************************************************************
	// Instruction hold registers
	//**************************************************************************
	always_ff @(posedge clk) begin
		if (state == core_pkg::M_IDLE && em.valid) begin
			cmd_q    <= em.mem_cmd;
			d_addr   <= {em.alu_out[31:2], 2'b00};
			rd       <= em.rd;
			wb_sel_q <= em.wb_sel;
			next_pc  <= em.next_pc;
			halt     <= em.is_ecall;
			result_q <= (em.wb_sel == core_pkg::WB_PC4) ? em.pc + 32'd4 : em.alu_out;
			// SB puts the byte on every lane and enables one
			if (em.mem_size == core_pkg::SIZE_BYTE) begin
				wdata <= {4{em.rs2_data[7:0]}};
				wmask <= 32'h0000_00ff << {em.alu_out[1:0], 3'b000};
			end else begin
				wdata <= em.rs2_data;
				wmask <= '1;
			end
		end
		if (state == core_pkg::M_WAIT_DATA && rdata_valid)
			load_q <= rdata;
	end

	a_retire_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		retire |=> !retire);

endmodule

/* rtl/core.sv */
`timescale 1ns/10ps

module core (
	input  logic                clk,
	input  logic                rst_n,
	output logic                inst_start,
	input  logic                inst_ready,
	output core_pkg::addr_t     inst_addr,
	input  core_pkg::inst_t     inst,
	input  logic                inst_valid,
	output core_pkg::mem_cmd_t  d_cmd,
	input  logic                d_cmd_ready,
	output core_pkg::addr_t     d_addr,
	output core_pkg::word_t     wdata,
	output core_pkg::wmask_t    wmask,
	input  core_pkg::word_t     rdata,
	input  logic                rdata_valid,
	output logic                halted
);

	// Retire bundle, memory stage back to fetch and register file
	logic                retire;
	core_pkg::reg_idx_t  ret_rd;
	core_pkg::word_t     ret_rd_data;
	logic                ret_rd_wen;
	core_pkg::addr_t     ret_next_pc;
	logic                ret_halt;

	fetch_dec_if fd_if ();
	dec_exe_if   de_if ();
	exe_mem_if   em_if ();

	fetch_stage i_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_ready (inst_ready),
		.inst       (inst),
		.inst_valid (inst_valid),
		.retire     (retire),
		.next_pc    (ret_next_pc),
		.halt       (ret_halt),
		.inst_start (inst_start),
		.inst_addr  (inst_addr),
		.halted     (halted),
		.fd         (fd_if)
	);

	decode_stage i_decode (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd_wen  (ret_rd_wen),
		.rd      (ret_rd),
		.rd_data (ret_rd_data),
		.fd      (fd_if),
		.de      (de_if)
	);

	execute_stage i_execute (
		.clk   (clk),
		.rst_n (rst_n),
		.de    (de_if),
		.em    (em_if)
	);

	memory_stage i_memory (
		.clk         (clk),
		.rst_n       (rst_n),
		.d_cmd_ready (d_cmd_ready),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.em          (em_if),
		.d_cmd       (d_cmd),
		.d_addr      (d_addr),
		.wdata       (wdata),
		.wmask       (wmask),
		.retire      (retire),
		.rd          (ret_rd),
		.rd_data     (ret_rd_data),
		.rd_wen      (ret_rd_wen),
		.next_pc     (ret_next_pc),
		.halt        (ret_halt)
	);

endmodule

/* tb/tb_mem_model.sv */
`timescale 1ns/10ps

module tb_mem_model (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                inst_start,
	input  core_pkg::addr_t     inst_addr,
	output logic                inst_ready,
	output core_pkg::inst_t     inst,
	output logic                inst_valid,
	input  core_pkg::mem_cmd_t  d_cmd,
	input  core_pkg::addr_t     d_addr,
	input  core_pkg::word_t     wdata,
	input  core_pkg::wmask_t    wmask,
	output logic                d_cmd_ready,
	output core_pkg::word_t     rdata,
	output logic                rdata_valid
);

	core_pkg::inst_t   rom [256];
	core_pkg::word_t   ram [256];
	core_pkg::addr_t   fetch_log [$];
	core_pkg::addr_t   st_addr [$];
	core_pkg::word_t   st_data [$];
	core_pkg::wmask_t  st_mask [$];
	int                err_count;
	logic [31:0]       lfsr;
	int                i_wait;
	int                d_wait;
	core_pkg::addr_t   i_req;
	core_pkg::addr_t   d_req;
	// Reset level seen at the last falling edge
	logic              running;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
		end
		return r;
	endfunction

	initial begin
		lfsr        = 32'd32216;
		err_count   = 0;
		i_wait      = 0;
		d_wait      = 0;
		running     = 1'b0;
		inst_ready  = 1'b0;
		inst        = '0;
		inst_valid  = 1'b0;
		d_cmd_ready = 1'b0;
		rdata       = '0;
		rdata_valid = 1'b0;
		for (int i = 0; i < 256; i++)
			ram[i] = 32'hc0de_0000 ^ (i * 32'h0001_0004);
		//**********************************************************************
		// Response driver, 1 ns after each rising edge
		//**********************************************************************
		forever begin
			@(posedge clk);
			#1;
			inst_valid  = 1'b0;
			rdata_valid = 1'b0;
			if (!running) begin
				inst_ready  = 1'b0;
				d_cmd_ready = 1'b0;
			end else begin
				if (i_wait > 0) begin
					i_wait--;
					if (i_wait == 0) begin
						inst       = rom[i_req[9:2]];
						inst_valid = 1'b1;
					end
				end
				if (d_wait > 0) begin
					d_wait--;
					if (d_wait == 0) begin
						rdata       = ram[d_req[9:2]];
						rdata_valid = 1'b1;
					end
				end
				inst_ready  = (i_wait == 0) && (rand_bits(2) != 32'd0);
				d_cmd_ready = (d_wait == 0) && (rand_bits(2) != 32'd0);
			end

			// Requests are taken at the falling edge, where the DUT outputs are settled
			@(negedge clk);
			running = rst_n;
			if (rst_n) begin
				if (inst_start) begin
					if (!inst_ready) begin
						err_count++;
						$display("instruction request issued while inst_ready was low");
					end
					fetch_log.push_back(inst_addr);
					i_req  = inst_addr;
					i_wait = 1 + rand_bits(2);
				end
				if (d_cmd != core_pkg::MEM_NONE && !d_cmd_ready) begin
					err_count++;
					$display("data command issued while d_cmd_ready was low");
				end
				if (d_cmd == core_pkg::MEM_WRITE) begin
					st_addr.push_back(d_addr);
					st_data.push_back(wdata);
					st_mask.push_back(wmask);
					ram[d_addr[9:2]] = (ram[d_addr[9:2]] & ~wmask) | (wdata & wmask);
				end else if (d_cmd == core_pkg::MEM_READ) begin
					d_req  = d_addr;
					d_wait = 1 + rand_bits(2);
				end
			end
		end
	end

endmodule

/* tb/tb_core.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module tb_core;

	logic                clk;
	logic                rst_n;
	logic                inst_start;
	logic                inst_ready;
	core_pkg::addr_t     inst_addr;
	core_pkg::inst_t     inst;
	logic                inst_valid;
	core_pkg::mem_cmd_t  d_cmd;
	logic                d_cmd_ready;
	core_pkg::addr_t     d_addr;
	core_pkg::word_t     wdata;
	core_pkg::wmask_t    wmask;
	core_pkg::word_t     rdata;
	logic                rdata_valid;
	logic                halted;

	core_pkg::inst_t   prog [256];
	int                prog_len;
	logic [31:0]       lfsr;
	core_pkg::addr_t   exp_fetch [$];
	core_pkg::addr_t   exp_addr [$];
	core_pkg::word_t   exp_data [$];
	core_pkg::wmask_t  exp_mask [$];
	int                mismatches;
	int                other_errs;

	core i_core (.*);

	tb_mem_model i_mem (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
		end
		return r;
	endfunction

	// x1 to x7 hold the random data
	function automatic core_pkg::reg_idx_t pick_reg();
		logic [31:0] r;
		r = rand_bits(3);
		return (r[2:0] == 3'd0) ? 5'd1 : {2'b00, r[2:0]};
	endfunction

	//**************************************************************************
	// Instruction encoders
	//**************************************************************************
	function automatic core_pkg::inst_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic core_pkg::inst_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic core_pkg::inst_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic core_pkg::inst_t enc_b(logic [12:0] imm, logic [4:0] rs1, logic [4:0] rs2,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic core_pkg::inst_t enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic core_pkg::inst_t enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic void emit(core_pkg::inst_t w);
		prog[prog_len] = w;
		prog_len++;
	endfunction

	task automatic gen_program();
		logic [31:0]         r;
		core_pkg::reg_idx_t  rd;
		core_pkg::reg_idx_t  rs1;
		core_pkg::reg_idx_t  rs2;
		logic [2:0]          f3;
		logic [11:0]         imm;
		logic [11:0]         off;
		prog_len = 0;
		for (int k = 1; k < 10; k++) begin
			r = rand_bits(12);
			emit(enc_i(r[11:0], 5'd0, 3'b000, 5'(k), 7'b0010011));
		end
		// x10 points at the data region
		emit(enc_i(12'h100, 5'd0, 3'b000, 5'd10, 7'b0010011));
		for (int k = 0; k < 40; k++) begin
			rd  = pick_reg();
			rs1 = pick_reg();
			rs2 = pick_reg();
			r   = rand_bits(6);
			f3  = r[2:0];
			off = {7'd0, r[5:3], 2'b00};
			r   = rand_bits(3);
			case (r[2:0])
				3'd0: begin
					r = rand_bits(1);
					emit(enc_r((r[0] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
						rs2, rs1, f3, rd));
				end
				3'd1: begin
					r   = rand_bits(13);
					imm = r[11:0];
					if (f3 == 3'd1)
						imm[11:5] = 7'h00;
					else if (f3 == 3'd5)
						imm[11:5] = r[12] ? 7'h20 : 7'h00;
					emit(enc_i(imm, rs1, f3, rd, 7'b0010011));
				end
				3'd2: begin
					r = rand_bits(21);
					emit(enc_u(r[19:0], rd, r[20] ? 7'b0110111 : 7'b0010111));
				end
				// Store, load back, then the final store below copies it
				3'd3: begin
					emit(enc_s(off, rs2, 5'd10, 3'b010));
					emit(enc_i(off, 5'd10, 3'b010, rd, 7'b0000011));
				end
				3'd4: begin
					r = rand_bits(5);
					emit(enc_s({5'd0, 2'b10, r[4:0]}, rs2, 5'd10, 3'b000));
				end
				3'd5: begin
					r = rand_bits(3);
					case (r[2:0])
						3'd0, 3'd6: f3 = 3'd0;
						3'd1, 3'd7: f3 = 3'd1;
						3'd2:       f3 = 3'd4;
						3'd3:       f3 = 3'd5;
						3'd4:       f3 = 3'd6;
						default:    f3 = 3'd7;
					endcase
					emit(enc_b(13'd8, rs1, rs2, f3));
					emit(enc_i(12'd1, rd, 3'b000, rd, 7'b0010011));
				end
				3'd6: begin
					emit(enc_j(21'd8, rd));
					emit(enc_i(12'hfff, 5'd0, 3'b000, rd, 7'b0010011));
				end
				default: begin
					emit(enc_u(20'd0, 5'd8, 7'b0010111));
					emit(enc_i(12'd12, 5'd8, 3'b000, rd, 7'b1100111));
					emit(enc_i(12'hfff, 5'd0, 3'b000, rd, 7'b0010011));
				end
			endcase
			emit(enc_s(off + 12'd32, rd, 5'd10, 3'b010));
		end
		emit(32'h0000_0073);
		for (int i = prog_len; i < 256; i++)
			prog[i] = 32'h0000_0073;
	endtask

	function automatic core_pkg::word_t ref_alu(logic [2:0] f3, core_pkg::word_t a,
		core_pkg::word_t b, logic alt, logic is_reg);
		case (f3)
			3'd0:    return (alt && is_reg) ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3:    return (a < b) ? 32'd1 : 32'd0;
			3'd4:    return a ^ b;
			3'd5:    return alt ? core_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	//**************************************************************************
	// Reference interpreter, fills the expected fetch and store lists
	//**************************************************************************
	function automatic void ref_run();
		core_pkg::word_t  regs [32];
		core_pkg::word_t  ram [256];
		core_pkg::addr_t  pc;
		core_pkg::addr_t  npc;
		core_pkg::addr_t  ea;
		core_pkg::inst_t  w;
		core_pkg::word_t  a;
		core_pkg::word_t  b;
		core_pkg::word_t  res;
		core_pkg::word_t  data;
		core_pkg::wmask_t mask;
		logic             wen;
		logic             take;
		logic             done;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			ram[i] = i_mem.ram[i];
		pc   = `RESET_PC;
		done = 1'b0;
		for (int step = 0; step < 2000 && !done; step++) begin
			exp_fetch.push_back(pc);
			w    = prog[pc[9:2]];
			a    = regs[w[19:15]];
			b    = regs[w[24:20]];
			npc  = pc + 32'd4;
			res  = '0;
			wen  = 1'b1;
			take = 1'b0;
			case (w[6:0])
				7'b0110111: res = {w[31:12], 12'h000};
				7'b0010111: res = pc + {w[31:12], 12'h000};
				7'b1101111: begin
					res = pc + 32'd4;
					npc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
				end
				7'b1100111: begin
					res = pc + 32'd4;
					npc = (a + {{20{w[31]}}, w[31:20]}) & ~32'd1;
				end
				7'b1100011: begin
					wen = 1'b0;
					case (w[14:12])
						3'd0:    take = a == b;
						3'd1:    take = a != b;
						3'd4:    take = $signed(a) < $signed(b);
						3'd5:    take = $signed(a) >= $signed(b);
						3'd6:    take = a < b;
						default: take = a >= b;
					endcase
					if (take)
						npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
				end
				7'b0000011: begin
					ea  = a + {{20{w[31]}}, w[31:20]};
					res = ram[ea[9:2]];
				end
				7'b0100011: begin
					wen = 1'b0;
					ea  = a + {{20{w[31]}}, w[31:25], w[11:7]};
					if (w[14:12] == 3'b010) begin
						data = b;
						mask = '1;
					end else begin
						data = {4{b[7:0]}};
						mask = 32'h0000_00ff << (8 * ea[1:0]);
					end
					exp_addr.push_back({ea[31:2], 2'b00});
					exp_data.push_back(data);
					exp_mask.push_back(mask);
					ram[ea[9:2]] = (ram[ea[9:2]] & ~mask) | (data & mask);
				end
				7'b0010011, 7'b0110011: begin
					res = ref_alu(w[14:12], a, w[5] ? b : {{20{w[31]}}, w[31:20]},
						w[30], w[5]);
				end
				default: done = 1'b1;
			endcase
			if (!done && wen && w[11:7] != 5'd0)
				regs[w[11:7]] = res;
			pc = npc;
		end
	endfunction

	task automatic check_addr(string name, core_pkg::addr_t got, core_pkg::addr_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_word(string name, core_pkg::word_t got, core_pkg::word_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_mask(string name, core_pkg::wmask_t got, core_pkg::wmask_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic print_counts();
		$display("errors: %0d mismatches, %0d other", mismatches, other_errs + i_mem.err_count);
	endtask

	initial begin
		int cyc;
		int nfetch;
		int n;
		rst_n      = 1'b0;
		mismatches = 0;
		other_errs = 0;
		lfsr       = 32'd32216;
		gen_program();
		for (int i = 0; i < 256; i++)
			i_mem.rom[i] = prog[i];
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			if (inst_start !== 1'b0 || halted !== 1'b0 || d_cmd !== core_pkg::MEM_NONE) begin
				other_errs++;
				$display("DUT outputs active during reset");
			end
		end
		ref_run();
		@(posedge clk);
		#1 rst_n = 1'b1;

		cyc = 0;
		while (halted !== 1'b1 && cyc < 20000) begin
			@(negedge clk);
			cyc++;
		end
		if (halted !== 1'b1) begin
			other_errs++;
			$display("timeout: halted never rose");
			print_counts();
			$display("Simulation failed");
			$finish;
		end else begin
			nfetch = i_mem.fetch_log.size();
			repeat (50) @(negedge clk);
			if (i_mem.fetch_log.size() != nfetch) begin
				other_errs++;
				$display("instruction fetch issued after halt");
			end

			//******************************************************************
			// Fetch sequence and store log against the reference
			//******************************************************************
			if (nfetch > 0)
				check_addr("first inst_addr", i_mem.fetch_log[0], `RESET_PC);
			if (nfetch != exp_fetch.size()) begin
				other_errs++;
				$display("fetch count differs: got %0d, expected %0d", nfetch, exp_fetch.size());
			end
			n = (nfetch < exp_fetch.size()) ? nfetch : exp_fetch.size();
			for (int i = 0; i < n; i++)
				check_addr("inst_addr", i_mem.fetch_log[i], exp_fetch[i]);
			if (i_mem.st_addr.size() != exp_addr.size()) begin
				other_errs++;
				$display("store count differs: got %0d, expected %0d",
					i_mem.st_addr.size(), exp_addr.size());
			end
			n = (i_mem.st_addr.size() < exp_addr.size()) ? i_mem.st_addr.size() : exp_addr.size();
			for (int i = 0; i < n; i++) begin
				check_addr("d_addr", i_mem.st_addr[i], exp_addr[i]);
				check_word("wdata", i_mem.st_data[i] & exp_mask[i], exp_data[i] & exp_mask[i]);
				check_mask("wmask", i_mem.st_mask[i], exp_mask[i]);
			end

			print_counts();
			if (mismatches == 0 && other_errs == 0 && i_mem.err_count == 0) begin
				$display("Simulation completed successfully");
			end else begin
				$display("Simulation failed");
			end
			$finish;
		end
	end

endmodule

/* list.f */
+incdir+rtl
rtl/core_pkg.sv
rtl/stage_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/core.sv
tb/tb_mem_model.sv
tb/tb_core.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f list.f --top-module tb_core -o sim_core; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/sim_core > sim.log 2>&1; then
	cat sim.log
	echo "Simulator returned an error status"
	exit 1
fi

cat sim.log
if grep -q "Simulation completed successfully" sim.log; then
	exit 0
fi
exit 1
